// File: build.f
+incdir+sim
rtl/wb_pkg.sv
rtl/wr_req_queue.sv
rtl/axi_wr_master.sv
rtl/write_buffer_top.sv
sim/wb_tb.sv

// File: rtl/axi_wr_master.sv
`timescale 1ns/10ps

module axi_wr_master (
    input  logic                        clock,
    input  logic                        reset,
    // request queue head
    input  logic                        head_valid_i,
    input  wb_pkg::wr_req_t             head_req_i,
    output logic                        head_pop_o,
    // AXI write address
    output logic [wb_pkg::ADDR_W-1:0]   awaddr_o,
    output logic [7:0]                  awlen_o,
    output logic [2:0]                  awsize_o,
    output logic                        awvalid_o,
    input  logic                        awready_i,
    // AXI write data
    output logic [wb_pkg::DATA_W-1:0]   wdata_o,
    output logic [wb_pkg::STRB_W-1:0]   wstrb_o,
    output logic                        wlast_o,
    output logic                        wvalid_o,
    input  logic                        wready_i,
    // AXI write response
    input  logic                        bvalid_i,
    output logic                        bready_o,
    output logic                        done_o
);
    import wb_pkg::*;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        ADDR = 2'd1,
        DATA = 2'd2,
        RESP = 2'd3
    } state_e;

    state_e              state_q;
    state_e              state_d;
    wr_req_t             req_q;        // request in flight, data shifts per beat
    logic [BEAT_W-1:0]   beat_q;
    logic [BEAT_W-1:0]   last_beat;
    logic                is_line;
    logic                w_fire;
    logic                done_q;

    assign is_line   = (req_q.wtype == LINE);
    assign last_beat = is_line ? BEAT_W'(LINE_BEATS - 1) : '0;
    assign w_fire    = wvalid_o && wready_i;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (head_valid_i) state_d = ADDR;
            ADDR: if (awready_i) state_d = DATA;
            DATA: if (w_fire && wlast_o) state_d = RESP;
            RESP: if (bvalid_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // control state
    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= IDLE;
            beat_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (head_pop_o) begin
                beat_q <= '0;
            end else if (w_fire) begin
                beat_q <= beat_q + 1'b1;
            end
            done_q <= (state_q == RESP) && bvalid_i;   // pulse after B transfer
        end
    end

    // request copy, lowest word leaves first
    always_ff @(posedge clock) begin
        if (head_pop_o) begin
            req_q <= head_req_i;
        end else if (w_fire) begin
            req_q.data <= req_q.data >> DATA_W;
        end
    end

    assign head_pop_o = (state_q == IDLE) && head_valid_i;

    // address channel
    assign awvalid_o = (state_q == ADDR);
    assign awaddr_o  = req_q.addr;
    assign awlen_o   = is_line ? 8'(LINE_BEATS - 1) : 8'd0;

    always_comb begin
        case (req_q.wtype)
            BYTE:    awsize_o = AXI_SIZE_1;
            HALF:    awsize_o = AXI_SIZE_2;
            default: awsize_o = AXI_SIZE_4;   // word and line
        endcase
    end

    // data channel
    assign wvalid_o = (state_q == DATA);
    assign wdata_o  = req_q.data[DATA_W-1:0];
    assign wstrb_o  = is_line ? {STRB_W{1'b1}} : req_q.strb;
    assign wlast_o  = (state_q == DATA) && (beat_q == last_beat);

    // response channel
    assign bready_o = (state_q == RESP);
    assign done_o   = done_q;

    a_aw_hold : assert property (
        @(posedge clock) disable iff (reset)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o)
            && $stable(awlen_o) && $stable(awsize_o)
    ) else $error("AW changed before handshake");

    a_w_hold : assert property (
        @(posedge clock) disable iff (reset)
        wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o)
            && $stable(wstrb_o) && $stable(wlast_o)
    ) else $error("W changed before handshake");

    // last beat must agree with the burst length sent on AW
    a_wlast_on_final : assert property (
        @(posedge clock) disable iff (reset)
        wvalid_o |-> (wlast_o == (beat_q == awlen_o[BEAT_W-1:0]))
    ) else $error("wlast does not match awlen");

endmodule

// File: rtl/wb_pkg.sv
package wb_pkg;

    // bus and line geometry
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int STRB_W      = DATA_W / 8;         // one strobe bit per byte lane
    localparam int LINE_W      = 128;                // 16 byte cache line
    localparam int LINE_BEATS  = LINE_W / DATA_W;    // beats per write-back burst
    localparam int BEAT_W      = $clog2(LINE_BEATS);

    // request queue
    localparam int QUEUE_DEPTH = 4;                  // also the credits after reset
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

    // AXI burst size codes, bytes per beat
    localparam logic [2:0] AXI_SIZE_1 = 3'd0;
    localparam logic [2:0] AXI_SIZE_2 = 3'd1;
    localparam logic [2:0] AXI_SIZE_4 = 3'd2;

    // encoding shared with the data cache
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010,
        LINE = 3'b100
    } wr_type_e;

    // one write request, 167 bits
    // single stores carry their data in the low word
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] data;
        logic [STRB_W-1:0] strb;   // ignored for LINE
        wr_type_e          wtype;
    } wr_req_t;

endpackage

// File: rtl/wr_req_queue.sv
`timescale 1ns/10ps

module wr_req_queue (
    input  logic            clock,
    input  logic            reset,
    input  logic            push_i,
    input  wb_pkg::wr_req_t push_req_i,
    output logic            head_valid_o,
    output wb_pkg::wr_req_t head_req_o,
    input  logic            pop_i,
    output logic            credit_o
);
    import wb_pkg::*;

    wr_req_t             mem [QUEUE_DEPTH];   // entry storage
    logic [QPTR_W-1:0]   wr_ptr;
    logic [QPTR_W-1:0]   rd_ptr;
    logic [QPTR_W:0]     count;               // needs one extra bit for full
    logic                credit_q;
    logic                empty;
    logic                full;

    assign empty = (count == '0);
    assign full  = (count == QUEUE_DEPTH[QPTR_W:0]);

    // entry payload
    always_ff @(posedge clock) begin
        if (push_i) begin
            mem[wr_ptr] <= push_req_i;
        end
    end

    // pointers, occupancy and credit return
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_q <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;        // wraps at the power-of-two depth
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
            credit_q <= pop_i;                  // one credit per freed entry
        end
    end

    assign head_valid_o = !empty;
    assign head_req_o   = mem[rd_ptr];
    assign credit_o     = credit_q;

    // the producer must never overrun its credits
    a_no_push_when_full : assert property (
        @(posedge clock) disable iff (reset)
        full |-> !push_i
    ) else $error("push into full request queue");

    // the master may only pop what head_valid announced
    a_no_pop_when_empty : assert property (
        @(posedge clock) disable iff (reset)
        pop_i |-> !empty
    ) else $error("pop from empty request queue");

endmodule

// File: rtl/write_buffer_top.sv
`timescale 1ns/10ps

module write_buffer_top (
    input  logic                        clock,
    input  logic                        reset,
    // cache side
    input  logic                        req_valid_i,
    input  logic [wb_pkg::ADDR_W-1:0]   req_addr_i,
    input  logic [wb_pkg::LINE_W-1:0]   req_data_i,
    input  logic [wb_pkg::STRB_W-1:0]   req_strb_i,
    input  wb_pkg::wr_type_e            req_type_i,
    output logic                        credit_o,
    output logic                        done_o,
    // AXI write address
    output logic [wb_pkg::ADDR_W-1:0]   awaddr_o,
    output logic [7:0]                  awlen_o,
    output logic [2:0]                  awsize_o,
    output logic                        awvalid_o,
    input  logic                        awready_i,
    // AXI write data
    output logic [wb_pkg::DATA_W-1:0]   wdata_o,
    output logic [wb_pkg::STRB_W-1:0]   wstrb_o,
    output logic                        wlast_o,
    output logic                        wvalid_o,
    input  logic                        wready_i,
    // AXI write response
    input  logic                        bvalid_i,
    output logic                        bready_o
);
    import wb_pkg::*;

    wr_req_t push_req;
    wr_req_t head_req;
    logic    head_valid;
    logic    head_pop;

    // cache fields into one request word
    assign push_req = '{
        addr:  req_addr_i,
        data:  req_data_i,
        strb:  req_strb_i,
        wtype: req_type_i
    };

    wr_req_queue wr_req_queue_inst (
        .clock        (clock),
        .reset        (reset),
        .push_i       (req_valid_i),
        .push_req_i   (push_req),
        .head_valid_o (head_valid),
        .head_req_o   (head_req),
        .pop_i        (head_pop),
        .credit_o     (credit_o)
    );

    axi_wr_master axi_wr_master_inst (
        .clock        (clock),
        .reset        (reset),
        .head_valid_i (head_valid),
        .head_req_i   (head_req),
        .head_pop_o   (head_pop),
        .awaddr_o     (awaddr_o),
        .awlen_o      (awlen_o),
        .awsize_o     (awsize_o),
        .awvalid_o    (awvalid_o),
        .awready_i    (awready_i),
        .wdata_o      (wdata_o),
        .wstrb_o      (wstrb_o),
        .wlast_o      (wlast_o),
        .wvalid_o     (wvalid_o),
        .wready_i     (wready_i),
        .bvalid_i     (bvalid_i),
        .bready_o     (bready_o),
        .done_o       (done_o)
    );

endmodule

// File: sim/wb_tb_table.svh
`ifndef WB_TB_TABLE_SVH
`define WB_TB_TABLE_SVH

// columns: kind, address, line data, strobe, expected awlen, awsize, beat words
// beat words are packed with beat 0 in the low 32 bits
typedef struct packed {
    wr_type_e                          wtype;
    logic [ADDR_W-1:0]                 addr;
    logic [LINE_W-1:0]                 data;
    logic [STRB_W-1:0]                 strb;
    logic [7:0]                        exp_len;
    logic [2:0]                        exp_size;
    logic [LINE_BEATS-1:0][DATA_W-1:0] exp_beats;
} test_t;

localparam int NUM_TESTS = 8;

test_t tests     [NUM_TESTS];
string test_name [NUM_TESTS];

task automatic put_test(input int idx, input string name, input wr_type_e wtype,
                        input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] data,
                        input logic [STRB_W-1:0] strb, input logic [7:0] exp_len,
                        input logic [2:0] exp_size, input logic [LINE_W-1:0] exp_beats);
    test_name[idx]       = name;
    tests[idx].wtype     = wtype;
    tests[idx].addr      = addr;
    tests[idx].data      = data;
    tests[idx].strb      = strb;
    tests[idx].exp_len   = exp_len;
    tests[idx].exp_size  = exp_size;
    tests[idx].exp_beats = exp_beats;
endtask

// upper words of single stores are junk and must not reach the bus
task automatic define_tests();
    put_test(0, "byte_store", BYTE, 32'h1000_0003,
             128'hdead_beef_dead_beef_dead_beef_a500_0000, 4'b1000, 8'd0, 3'd0, 128'ha500_0000);
    put_test(1, "half_store", HALF, 32'h1000_0012,
             128'h1111_2222_3333_4444_5555_6666_5a5a_0000, 4'b1100, 8'd0, 3'd1, 128'h5a5a_0000);
    put_test(2, "word_store", WORD, 32'h1000_0020,
             128'hffff_ffff_ffff_ffff_ffff_ffff_1234_5678, 4'b1111, 8'd0, 3'd2, 128'h1234_5678);
    put_test(3, "line_wb_a", LINE, 32'h2000_0040,
             128'h4444_4444_3333_3333_2222_2222_1111_1111, 4'b0000, 8'd3, 3'd2,
             128'h4444_4444_3333_3333_2222_2222_1111_1111);
    put_test(4, "line_wb_b", LINE, 32'h2000_0080,
             128'hcafe_0003_cafe_0002_cafe_0001_cafe_0000, 4'b0101, 8'd3, 3'd2,
             128'hcafe_0003_cafe_0002_cafe_0001_cafe_0000);
    put_test(5, "byte_store_2", BYTE, 32'h3000_0001,
             128'h0123_4567_89ab_cdef_0000_0000_0000_3c00, 4'b0010, 8'd0, 3'd0, 128'h3c00);
    put_test(6, "word_store_2", WORD, 32'h3000_0104,
             128'h7777_7777_7777_7777_7777_7777_89ab_cdef, 4'b1111, 8'd0, 3'd2, 128'h89ab_cdef);
    put_test(7, "line_wb_c", LINE, 32'h4000_00c0,
             128'h0f0e_0d0c_0b0a_0908_0706_0504_0302_0100, 4'b0000, 8'd3, 3'd2,
             128'h0f0e_0d0c_0b0a_0908_0706_0504_0302_0100);
endtask

`endif

// File: sim/wb_tb.sv
`timescale 1ns/10ps

module wb_tb;
    import wb_pkg::*;

    `include "wb_tb_table.svh"

    localparam int TIMEOUT_CYCLES = NUM_TESTS * 40 + 100;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
    } aw_rec_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_rec_t;

    logic              clock;
    logic              reset;
    logic              req_valid_i;
    logic [ADDR_W-1:0] req_addr_i;
    logic [LINE_W-1:0] req_data_i;
    logic [STRB_W-1:0] req_strb_i;
    wr_type_e          req_type_i;
    logic              credit_o;
    logic              done_o;
    logic [ADDR_W-1:0] awaddr_o;
    logic [7:0]        awlen_o;
    logic [2:0]        awsize_o;
    logic              awvalid_o;
    logic              awready_i;
    logic [DATA_W-1:0] wdata_o;
    logic [STRB_W-1:0] wstrb_o;
    logic              wlast_o;
    logic              wvalid_o;
    logic              wready_i;
    logic              bvalid_i;
    logic              bready_o;

    logic    hold_aw;                 // keeps awready low for the stall test
    logic    b_fire_q;
    int      credits;                 // producer side credit counter
    int      sent_cnt    = 0;
    int      credit_cnt  = 0;
    int      done_cnt    = 0;
    int      err_cnt     = 0;
    int      pass_cnt    = 0;
    int      fail_cnt    = 0;
    int      cycle_cnt   = 0;
    aw_rec_t aw_q [$];
    w_rec_t  w_q [$];
    int      aw_stalls [$];
    int      w_stalls [$];
    int      b_stalls [$];

    write_buffer_top write_buffer_top_inst (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
            $display("sim failed");
            $finish;
        end
    end

    // AXI transfer capture, credit and done bookkeeping
    always @(posedge clock) begin
        int next_credits;
        next_credits = credits - int'(req_valid_i) + int'(credit_o);
        if (reset) begin
            credits  <= QUEUE_DEPTH;
            b_fire_q <= 1'b0;
        end else begin
            if (next_credits < 0 || next_credits > QUEUE_DEPTH) begin
                $display("credit counter left its range, now %0d", next_credits);
                err_cnt++;
            end
            credits <= next_credits;
            if (awvalid_o && awready_i) aw_q.push_back('{awaddr_o, awlen_o, awsize_o});
            if (wvalid_o && wready_i) w_q.push_back('{wdata_o, wstrb_o, wlast_o});
            if (credit_o) credit_cnt++;
            if (done_o !== b_fire_q) begin
                $display("done_o does not follow the B transfer at cycle %0d", cycle_cnt);
                err_cnt++;
            end
            if (done_o) done_cnt++;
            b_fire_q <= bvalid_i && bready_o;
        end
    end

    initial begin
        int stall;
        @(negedge clock);
        forever begin
            if (awvalid_o && !hold_aw) begin
                stall = (aw_stalls.size() > 0) ? aw_stalls.pop_front() : 0;
                repeat (stall) @(negedge clock);
                awready_i = 1'b1;
                @(negedge clock);
                awready_i = 1'b0;
            end else begin
                @(negedge clock);
            end
        end
    end

    initial begin
        int stall;
        @(negedge clock);
        forever begin
            if (wvalid_o) begin
                stall = (w_stalls.size() > 0) ? w_stalls.pop_front() : 0;
                repeat (stall) @(negedge clock);
                wready_i = 1'b1;
                @(negedge clock);
                wready_i = 1'b0;
            end else begin
                @(negedge clock);
            end
        end
    end

    initial begin
        int stall;
        @(negedge clock);
        forever begin
            if (bready_o) begin
                stall = (b_stalls.size() > 0) ? b_stalls.pop_front() : 0;
                repeat (stall) @(negedge clock);
                bvalid_i = 1'b1;          // bready stays up until this is taken
                @(negedge clock);
                bvalid_i = 1'b0;
            end else begin
                @(negedge clock);
            end
        end
    end

    // all stall lengths come from the one seeded thread
    task automatic draw_stalls();
        int n;
        for (n = 0; n < NUM_TESTS; n++) begin
            aw_stalls.push_back($urandom_range(3));
            b_stalls.push_back($urandom_range(2));
        end
        for (n = 0; n < NUM_TESTS * LINE_BEATS; n++) begin
            w_stalls.push_back($urandom_range(3));
        end
    endtask

    task automatic run_producer();
        int i;
        for (i = 0; i < NUM_TESTS; i++) begin
            while (credits == 0) @(negedge clock);
            req_valid_i = 1'b1;
            req_addr_i  = tests[i].addr;
            req_data_i  = tests[i].data;
            req_strb_i  = tests[i].strb;
            req_type_i  = tests[i].wtype;
            @(negedge clock);
            req_valid_i = 1'b0;
            sent_cnt++;
        end
    endtask

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("** Error %s: %s expected %h, actual %h", name, field, exp, act);
        err_cnt++;
    endtask

    task automatic close_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %-14s passed", name);
        end else begin
            fail_cnt++;
            $display("test %-14s failed", name);
        end
    endtask

    task automatic check_test(input int i);
        aw_rec_t           aw;
        w_rec_t            w;
        logic [STRB_W-1:0] exp_strb;
        int                errs_before;
        int                b;
        errs_before = err_cnt;
        exp_strb    = (tests[i].wtype == LINE) ? 4'hf : tests[i].strb;
        if (aw_q.size() == 0) begin
            $display("%s: no AW transfer was seen", test_name[i]);
            err_cnt++;
        end else begin
            aw = aw_q.pop_front();
            if (aw.addr !== tests[i].addr) begin
                report_mismatch(test_name[i], "awaddr", tests[i].addr, aw.addr);
            end
            if (aw.len !== tests[i].exp_len) begin
                report_mismatch(test_name[i], "awlen", tests[i].exp_len, aw.len);
            end
            if (aw.size !== tests[i].exp_size) begin
                report_mismatch(test_name[i], "awsize", tests[i].exp_size, aw.size);
            end
        end
        for (b = 0; b <= tests[i].exp_len; b++) begin
            if (w_q.size() == 0) begin
                $display("%s: W burst ended after %0d beats", test_name[i], b);
                err_cnt++;
                break;
            end
            w = w_q.pop_front();
            if (w.data !== tests[i].exp_beats[b]) begin
                report_mismatch(test_name[i], "wdata", tests[i].exp_beats[b], w.data);
            end
            if (w.strb !== exp_strb) begin
                report_mismatch(test_name[i], "wstrb", exp_strb, w.strb);
            end
            if (w.last !== (b == tests[i].exp_len)) begin
                report_mismatch(test_name[i], "wlast", b == tests[i].exp_len, w.last);
            end
        end
        close_test(test_name[i], errs_before);
    endtask

    initial begin
        int i;
        int errs;
        void'($urandom(45));
        reset       = 1'b1;
        req_valid_i = 1'b0;
        req_addr_i  = '0;
        req_data_i  = '0;
        req_strb_i  = '0;
        req_type_i  = BYTE;
        awready_i   = 1'b0;
        wready_i    = 1'b0;
        bvalid_i    = 1'b0;
        hold_aw     = 1'b1;
        define_tests();
        draw_stalls();
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        errs = err_cnt;
        if (awvalid_o !== 1'b0) report_mismatch("after_reset", "awvalid", 0, awvalid_o);
        if (wvalid_o !== 1'b0) report_mismatch("after_reset", "wvalid", 0, wvalid_o);
        if (bready_o !== 1'b0) report_mismatch("after_reset", "bready", 0, bready_o);
        if (credit_o !== 1'b0) report_mismatch("after_reset", "credit", 0, credit_o);
        if (done_o !== 1'b0) report_mismatch("after_reset", "done", 0, done_o);
        close_test("after_reset", errs);

        fork
            run_producer();
        join_none

        // with AW blocked the master holds one request while the queue fills behind it
        errs = err_cnt;
        while (credits != 0) @(negedge clock);
        repeat (8) @(negedge clock);
        if (sent_cnt != QUEUE_DEPTH + 1) begin
            report_mismatch("credit_stall", "accepted", QUEUE_DEPTH + 1, sent_cnt);
        end
        if (credit_cnt != 1) report_mismatch("credit_stall", "credit pulses", 1, credit_cnt);
        if (credits != 0) report_mismatch("credit_stall", "credits", 0, credits);
        if (awvalid_o !== 1'b1) report_mismatch("credit_stall", "awvalid", 1, awvalid_o);
        close_test("credit_stall", errs);
        hold_aw = 1'b0;

        for (i = 0; i < NUM_TESTS; i++) begin
            while (done_cnt <= i) @(negedge clock);
            check_test(i);
        end

        repeat (2) @(negedge clock);
        errs = err_cnt;
        if (awvalid_o !== 1'b0) report_mismatch("drain", "awvalid", 0, awvalid_o);
        if (wvalid_o !== 1'b0) report_mismatch("drain", "wvalid", 0, wvalid_o);
        if (sent_cnt != NUM_TESTS) report_mismatch("drain", "requests sent", NUM_TESTS, sent_cnt);
        if (credit_cnt != NUM_TESTS) begin
            report_mismatch("drain", "credit pulses", NUM_TESTS, credit_cnt);
        end
        if (done_cnt != NUM_TESTS) report_mismatch("drain", "done pulses", NUM_TESTS, done_cnt);
        if (credits != QUEUE_DEPTH) report_mismatch("drain", "credits", QUEUE_DEPTH, credits);
        if (aw_q.size() != 0 || w_q.size() != 0) begin
            $display("drain: extra AXI transfers were seen after the last request");
            err_cnt++;
        end
        close_test("drain", errs);

        $display("%0d tests passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
